// File: hw/tcdm_pkg.sv
// shared constants and types of the banked memory path, imported by every block of the design
package tcdm_pkg;

  // streamer channels and memory banks
  localparam int unsigned NB_CHAN    = 4;
  localparam int unsigned NB_BANK    = 4;
  localparam int unsigned BANK_WORDS = 64;

  // bus widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned BE_W   = DATA_W / 8;

  // address fields: byte offset, bank select, row inside the bank
  localparam int unsigned OFFS_W     = $clog2(BE_W);
  localparam int unsigned BANK_SEL_W = $clog2(NB_BANK);
  localparam int unsigned ROW_W      = $clog2(BANK_WORDS);

  // byte address
  typedef logic [ADDR_W-1:0] tcdm_addr_t;

  // one data word and its byte enables
  typedef logic [DATA_W-1:0] tcdm_data_t;
  typedef logic [BE_W-1:0]   tcdm_be_t;

  // bank index, also used as the channel rotation offset
  typedef logic [BANK_SEL_W-1:0] bank_sel_t;

  // word row inside one bank
  typedef logic [ROW_W-1:0] row_t;

endpackage

// File: hw/tcdm_intf.sv
// one request/response memory port, used between the decode, reorder, bank and collector blocks
interface tcdm_intf;
  import tcdm_pkg::*;

  // request side
  logic       req;
  tcdm_addr_t add;
  // high means read
  logic       wen;
  tcdm_be_t   be;
  tcdm_data_t data;
  logic       gnt;

  // response side
  tcdm_data_t r_data;
  logic       r_valid;

  modport master (
    output req,
    output add,
    output wen,
    output be,
    output data,
    input  gnt,
    input  r_data,
    input  r_valid
  );

  modport slave (
    input  req,
    input  add,
    input  wen,
    input  be,
    input  data,
    output gnt,
    output r_data,
    output r_valid
  );

  // passive view for blocks that only watch the port
  modport monitor (
    input req,
    input add,
    input wen,
    input be,
    input data,
    input gnt,
    input r_data,
    input r_valid
  );

endinterface

// File: hw/tcdm_chan_decode.sv
// registers a streamer command and expands it into one request per channel plus the bank offset
module tcdm_chan_decode (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  logic                                        clear_i,
  input  logic                                        cmd_valid_i,
  input  logic                                        cmd_read_i,
  input  tcdm_pkg::tcdm_addr_t                        cmd_addr_i,
  input  tcdm_pkg::tcdm_be_t   [tcdm_pkg::NB_CHAN-1:0] cmd_be_i,
  input  tcdm_pkg::tcdm_data_t [tcdm_pkg::NB_CHAN-1:0] cmd_wdata_i,
  output logic                                        cmd_ready_o,
  output tcdm_pkg::bank_sel_t                         order_o,
  tcdm_intf.master                                    chan_o [tcdm_pkg::NB_CHAN-1:0]
);
  import tcdm_pkg::*;

  // pending request state
  logic pend_q;
  logic read_q;

  // command payload, kept until granted
  tcdm_addr_t               addr_q;
  tcdm_be_t   [NB_CHAN-1:0] be_q;
  tcdm_data_t [NB_CHAN-1:0] wdata_q;

  logic [NB_CHAN-1:0] chan_gnt;
  logic               granted;
  logic               accept;

  // all channels move together, so wait for every grant
  assign granted     = &chan_gnt;
  assign cmd_ready_o = ~pend_q | granted;
  assign accept      = cmd_valid_i & cmd_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q <= 1'b0;
    end else if (clear_i) begin
      pend_q <= 1'b0;
    end else if (accept) begin
      pend_q <= 1'b1;
    end else if (granted) begin
      pend_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      read_q  <= cmd_read_i;
      addr_q  <= cmd_addr_i;
      be_q    <= cmd_be_i;
      wdata_q <= cmd_wdata_i;
    end
  end

  // channel 0 lands on bank w mod NB_BANK
  assign order_o = addr_q[OFFS_W +: BANK_SEL_W];

  for (genvar i = 0; i < NB_CHAN; i++) begin : gen_chan
    // consecutive words, one per channel
    assign chan_o[i].req  = pend_q;
    assign chan_o[i].add  = addr_q + tcdm_addr_t'(i * BE_W);
    assign chan_o[i].wen  = read_q;
    assign chan_o[i].be   = be_q[i];
    assign chan_o[i].data = wdata_q[i];

    assign chan_gnt[i] = chan_o[i].gnt;
  end

endmodule

// File: hw/tcdm_reorder.sv
// rotates streamer channels onto memory banks and routes the bank responses back per channel
module tcdm_reorder #(
  parameter int unsigned FILTER_WRITE_R_VALID = 0
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                clear_i,
  input  tcdm_pkg::bank_sel_t order_i,
  tcdm_intf.slave             in_i  [tcdm_pkg::NB_CHAN-1:0],
  tcdm_intf.master            out_o [tcdm_pkg::NB_BANK-1:0]
);
  import tcdm_pkg::*;

  // channel side
  logic       [NB_CHAN-1:0] in_req;
  logic       [NB_CHAN-1:0] in_req_q;
  tcdm_addr_t [NB_CHAN-1:0] in_add;
  logic       [NB_CHAN-1:0] in_wen;
  tcdm_be_t   [NB_CHAN-1:0] in_be;
  tcdm_data_t [NB_CHAN-1:0] in_data;
  logic       [NB_CHAN-1:0] in_gnt;
  tcdm_data_t [NB_CHAN-1:0] in_r_data;
  logic       [NB_CHAN-1:0] in_r_valid;

  // target bank now and one cycle ago
  bank_sel_t [NB_CHAN-1:0] sel;
  bank_sel_t [NB_CHAN-1:0] sel_q;

  // bank side
  logic       [NB_BANK-1:0] out_req;
  tcdm_addr_t [NB_BANK-1:0] out_add;
  logic       [NB_BANK-1:0] out_wen;
  tcdm_be_t   [NB_BANK-1:0] out_be;
  tcdm_data_t [NB_BANK-1:0] out_data;
  logic       [NB_BANK-1:0] out_gnt;
  tcdm_data_t [NB_BANK-1:0] out_r_data;
  logic       [NB_BANK-1:0] out_r_valid;

  // request matrix and its transpose
  logic [NB_CHAN-1:0][NB_BANK-1:0] ma_req;
  logic [NB_BANK-1:0][NB_CHAN-1:0] mat_req;

  logic all_gnt;

  // granted only when no requesting bank stalls
  assign all_gnt = &(~out_req | out_gnt);

  for (genvar i = 0; i < NB_CHAN; i++) begin : gen_in_chan
    assign in_req[i]  = in_i[i].req;
    assign in_add[i]  = in_i[i].add;
    assign in_wen[i]  = in_i[i].wen;
    assign in_be[i]   = in_i[i].be;
    assign in_data[i] = in_i[i].data;

    assign sel[i]    = order_i + bank_sel_t'(i);
    assign in_gnt[i] = all_gnt;

    for (genvar b = 0; b < NB_BANK; b++) begin : gen_matrix
      assign ma_req[i][b]  = in_req[i] & (sel[i] == bank_sel_t'(b));
      assign mat_req[b][i] = ma_req[i][b];
    end

    // remember which requests expect a response next cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        in_req_q[i] <= 1'b0;
        sel_q[i]    <= '0;
      end else if (clear_i) begin
        in_req_q[i] <= 1'b0;
      end else begin
        if (FILTER_WRITE_R_VALID != 0) begin
          in_req_q[i] <= in_req[i] & in_gnt[i] & in_wen[i];
        end else begin
          in_req_q[i] <= in_req[i] & in_gnt[i];
        end
        if (in_req[i] & in_gnt[i]) begin
          sel_q[i] <= sel[i];
        end
      end
    end

    assign in_r_data[i]  = out_r_data[sel_q[i]];
    assign in_r_valid[i] = out_r_valid[sel_q[i]] & in_req_q[i];

    assign in_i[i].gnt     = in_gnt[i];
    assign in_i[i].r_data  = in_r_data[i];
    assign in_i[i].r_valid = in_r_valid[i];
  end

  for (genvar b = 0; b < NB_BANK; b++) begin : gen_out_bank
    // channels never collide on a bank, so a plain OR merges them
    always_comb begin
      out_req[b]  = 1'b0;
      out_add[b]  = '0;
      out_wen[b]  = 1'b0;
      out_be[b]   = '0;
      out_data[b] = '0;
      for (int j = 0; j < NB_CHAN; j++) begin
        out_req[b]  |= mat_req[b][j];
        out_add[b]  |= mat_req[b][j] ? in_add[j]  : '0;
        out_wen[b]  |= mat_req[b][j] & in_wen[j];
        out_be[b]   |= mat_req[b][j] ? in_be[j]   : '0;
        out_data[b] |= mat_req[b][j] ? in_data[j] : '0;
      end
    end

    assign out_o[b].req  = out_req[b];
    assign out_o[b].add  = out_add[b];
    assign out_o[b].wen  = out_wen[b];
    assign out_o[b].be   = out_be[b];
    assign out_o[b].data = out_data[b];

    assign out_gnt[b]     = out_o[b].gnt;
    assign out_r_data[b]  = out_o[b].r_data;
    assign out_r_valid[b] = out_o[b].r_valid;
  end

endmodule

// File: hw/tcdm_bank_mem.sv
// single-port memory bank with byte-enabled writes and a one-cycle response, one per bank port
module tcdm_bank_mem (
  input  logic    clk_i,
  input  logic    rst_ni,
  tcdm_intf.slave port_i
);
  import tcdm_pkg::*;

  // storage
  tcdm_data_t mem_q [BANK_WORDS];

  row_t       row;
  logic       r_valid_q;
  tcdm_data_t r_data_q;

  // bank bits are already resolved by the reorder, keep only the row
  assign row = port_i.add[OFFS_W + BANK_SEL_W +: ROW_W];

  // no contention on a bank
  assign port_i.gnt = 1'b1;

  always_ff @(posedge clk_i) begin
    if (port_i.req) begin
      if (port_i.wen) begin
        r_data_q <= mem_q[row];
      end else begin
        for (int b = 0; b < BE_W; b++) begin
          if (port_i.be[b]) begin
            mem_q[row][8*b +: 8] <= port_i.data[8*b +: 8];
          end
        end
      end
    end
  end

  // writes are answered too
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= port_i.req;
    end
  end

  assign port_i.r_data  = r_data_q;
  assign port_i.r_valid = r_valid_q;

endmodule

// File: hw/tcdm_resp_collect.sv
// collects the per-channel read data into one registered response vector for the top level
module tcdm_resp_collect (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  logic                                        clear_i,
  tcdm_intf.monitor                                   chan_i [tcdm_pkg::NB_CHAN-1:0],
  output logic                                        rsp_valid_o,
  output tcdm_pkg::tcdm_data_t [tcdm_pkg::NB_CHAN-1:0] rsp_rdata_o
);
  import tcdm_pkg::*;

  logic       [NB_CHAN-1:0] chan_valid;
  tcdm_data_t [NB_CHAN-1:0] chan_rdata;
  logic                     all_valid;

  // response register
  logic                     valid_q;
  tcdm_data_t [NB_CHAN-1:0] rdata_q;

  for (genvar i = 0; i < NB_CHAN; i++) begin : gen_chan
    assign chan_valid[i] = chan_i[i].r_valid;
    assign chan_rdata[i] = chan_i[i].r_data;
  end

  // a partial set of valids is dropped here
  assign all_valid = &chan_valid;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (clear_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= all_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (all_valid) begin
      rdata_q <= chan_rdata;
    end
  end

  assign rsp_valid_o = valid_q;
  assign rsp_rdata_o = rdata_q;

endmodule

// File: hw/tcdm_subsys_top.sv
// top level of the banked memory path, connects decode, reorder, banks and response collector
module tcdm_subsys_top (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  logic                                        clear_i,
  input  logic                                        cmd_valid_i,
  input  logic                                        cmd_read_i,
  input  tcdm_pkg::tcdm_addr_t                        cmd_addr_i,
  input  tcdm_pkg::tcdm_be_t   [tcdm_pkg::NB_CHAN-1:0] cmd_be_i,
  input  tcdm_pkg::tcdm_data_t [tcdm_pkg::NB_CHAN-1:0] cmd_wdata_i,
  output logic                                        cmd_ready_o,
  output logic                                        rsp_valid_o,
  output tcdm_pkg::tcdm_data_t [tcdm_pkg::NB_CHAN-1:0] rsp_rdata_o
);
  import tcdm_pkg::*;

  // channel ports and bank ports
  tcdm_intf chan_if [NB_CHAN-1:0] ();
  tcdm_intf bank_if [NB_BANK-1:0] ();

  bank_sel_t order;

  tcdm_chan_decode u_decode (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .clear_i     ( clear_i     ),
    .cmd_valid_i ( cmd_valid_i ),
    .cmd_read_i  ( cmd_read_i  ),
    .cmd_addr_i  ( cmd_addr_i  ),
    .cmd_be_i    ( cmd_be_i    ),
    .cmd_wdata_i ( cmd_wdata_i ),
    .cmd_ready_o ( cmd_ready_o ),
    .order_o     ( order       ),
    .chan_o      ( chan_if     )
  );

  // write responses stay inside the reorder
  tcdm_reorder #(
    .FILTER_WRITE_R_VALID ( 1 )
  ) u_reorder (
    .clk_i   ( clk_i   ),
    .rst_ni  ( rst_ni  ),
    .clear_i ( clear_i ),
    .order_i ( order   ),
    .in_i    ( chan_if ),
    .out_o   ( bank_if )
  );

  for (genvar b = 0; b < NB_BANK; b++) begin : gen_bank
    tcdm_bank_mem u_bank (
      .clk_i  ( clk_i      ),
      .rst_ni ( rst_ni     ),
      .port_i ( bank_if[b] )
    );
  end

  tcdm_resp_collect u_collect (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .clear_i     ( clear_i     ),
    .chan_i      ( chan_if     ),
    .rsp_valid_o ( rsp_valid_o ),
    .rsp_rdata_o ( rsp_rdata_o )
  );

endmodule

// File: tests/tcdm_subsys_assertions.sv
// concurrent checks on the channel to bank reorder, bound into every tcdm_reorder instance
module tcdm_reorder_assertions (
  input logic                                              clk_i,
  input logic                                              rst_ni,
  input logic                                              filter_i,
  input logic [tcdm_pkg::NB_CHAN-1:0]                      req_i,
  input logic [tcdm_pkg::NB_CHAN-1:0]                      gnt_i,
  input logic [tcdm_pkg::NB_CHAN-1:0]                      wen_i,
  input logic [tcdm_pkg::NB_CHAN-1:0]                      r_valid_i,
  input logic [tcdm_pkg::NB_BANK-1:0][tcdm_pkg::NB_CHAN-1:0] bank_req_i
);
  import tcdm_pkg::*;

  for (genvar b = 0; b < NB_BANK; b++) begin : gen_bank
    // at most one channel per bank
    assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(bank_req_i[b]))
      else $error("bank %0d requested by more than one channel", b);
  end

  for (genvar i = 0; i < NB_CHAN; i++) begin : gen_chan
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      r_valid_i[i] |-> $past(req_i[i] & gnt_i[i]))
      else $error("channel %0d r_valid without a granted request", i);

    // only reads are answered when filtering
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      (filter_i && r_valid_i[i]) |-> $past(wen_i[i]))
      else $error("channel %0d r_valid after a write", i);
  end

endmodule

bind tcdm_reorder tcdm_reorder_assertions u_reorder_assert (
  .clk_i      ( clk_i                     ),
  .rst_ni     ( rst_ni                    ),
  .filter_i   ( FILTER_WRITE_R_VALID != 0 ),
  .req_i      ( in_req                    ),
  .gnt_i      ( in_gnt                    ),
  .wen_i      ( in_wen                    ),
  .r_valid_i  ( in_r_valid                ),
  .bank_req_i ( mat_req                   )
);

// File: tests/tcdm_subsys_tb.sv
// testbench for the banked memory path, drives commands and checks reads against a reference memory
module tcdm_subsys_tb;
  import tcdm_pkg::*;

  localparam int unsigned TOTAL_WORDS = NB_BANK * BANK_WORDS;
  localparam int unsigned FILL_CMDS   = TOTAL_WORDS / NB_CHAN;
  localparam int unsigned RAND_READS  = 24;
  // aligned, rotation, partial and clear tests
  localparam int unsigned OTHER_CMDS  = 2 + 2 * NB_BANK + 3 + 2;
  localparam int unsigned TIMEOUT_CYC = (FILL_CMDS + RAND_READS + OTHER_CMDS) * 10 + 100;

  typedef tcdm_data_t [NB_CHAN-1:0] word_vec_t;
  typedef tcdm_be_t   [NB_CHAN-1:0] be_vec_t;
  typedef logic [$clog2(TOTAL_WORDS)-1:0] word_idx_t;

  logic       clk_i;
  logic       rst_ni;
  logic       clear_i;
  logic       cmd_valid_i;
  logic       cmd_read_i;
  tcdm_addr_t cmd_addr_i;
  be_vec_t    cmd_be_i;
  word_vec_t  cmd_wdata_i;
  logic       cmd_ready_o;
  logic       rsp_valid_o;
  word_vec_t  rsp_rdata_o;

  // reference memory, one entry per word
  tcdm_data_t  ref_mem [TOTAL_WORDS];
  word_vec_t   exp_q [$];
  logic [31:0] lfsr_q = 32'h1e3b4ba4;

  string       cur_test;
  int unsigned checks, errors, rsp_count, err_start, rsp_start, tests_run, tests_failed;

  tcdm_subsys_top dut (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .clear_i     ( clear_i     ),
    .cmd_valid_i ( cmd_valid_i ),
    .cmd_read_i  ( cmd_read_i  ),
    .cmd_addr_i  ( cmd_addr_i  ),
    .cmd_be_i    ( cmd_be_i    ),
    .cmd_wdata_i ( cmd_wdata_i ),
    .cmd_ready_o ( cmd_ready_o ),
    .rsp_valid_o ( rsp_valid_o ),
    .rsp_rdata_o ( rsp_rdata_o )
  );

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;

  // taps of x^32 + x^22 + x^2 + x + 1 with one shift per bit taken
  function automatic logic [31:0] take_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned k = 0; k < n; k++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      v      = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic word_vec_t rand_words();
    word_vec_t v;
    for (int i = 0; i < NB_CHAN; i++) begin
      v[i] = take_bits(DATA_W);
    end
    return v;
  endfunction

  // a write keeps the old byte wherever its enable is low
  function automatic tcdm_data_t merge_word(tcdm_data_t old_w, tcdm_data_t new_w, tcdm_be_t be);
    tcdm_data_t r;
    r = old_w;
    for (int b = 0; b < BE_W; b++) begin
      if (be[b]) begin
        r[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return r;
  endfunction

  task automatic check_word(input string what, input tcdm_data_t exp, input tcdm_data_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: expected %08h, actual %08h", what, exp, act);
    end
  endtask

  task automatic check_count(input string what, input int unsigned exp, input int unsigned act);
    checks++;
    if (act != exp) begin
      errors++;
      $display("[ERROR] %s: expected %0d, actual %0d", what, exp, act);
    end
  endtask

  // drives one command just after the edge and queues the words a read expects
  task automatic send_cmd(input logic rd, input word_idx_t w, input be_vec_t be,
                          input word_vec_t wdata, input logic expect_rsp);
    int unsigned tries;
    @(posedge clk_i);
    #1;
    cmd_valid_i = 1'b1;
    cmd_read_i  = rd;
    cmd_addr_i  = tcdm_addr_t'(w) << OFFS_W;
    cmd_be_i    = be;
    cmd_wdata_i = wdata;
    clear_i     = 1'b0;
    for (int i = 0; i < NB_CHAN; i++) begin
      if (!rd) begin
        ref_mem[w + word_idx_t'(i)] = merge_word(ref_mem[w + word_idx_t'(i)], wdata[i], be[i]);
      end
    end
    if (rd && expect_rsp) begin
      exp_q.push_back({ref_mem[w + word_idx_t'(3)], ref_mem[w + word_idx_t'(2)],
                       ref_mem[w + word_idx_t'(1)], ref_mem[w]});
    end
    tries = 0;
    @(negedge clk_i);
    while (!cmd_ready_o && tries < 8) begin
      tries++;
      @(negedge clk_i);
    end
    if (!cmd_ready_o) begin
      errors++;
      $display("%s: cmd_ready_o stayed low, command not accepted", cur_test);
    end
  endtask

  task automatic idle(input int unsigned n, input logic clr);
    repeat (n) begin
      @(posedge clk_i);
      #1;
      cmd_valid_i = 1'b0;
      clear_i     = clr;
    end
  endtask

  task automatic wait_drain();
    int unsigned n;
    n = 0;
    while (exp_q.size() != 0 && n < 20) begin
      @(negedge clk_i);
      n++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("%s: %0d read responses never arrived", cur_test, exp_q.size());
      exp_q.delete();
    end
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    err_start = errors;
    rsp_start = rsp_count;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors != err_start) begin
      tests_failed++;
      $display("[FAIL] %s: %0d errors", cur_test, errors - err_start);
    end else begin
      $display("[PASS] %s", cur_test);
    end
  endtask

  // compares responses away from the driving edge
  always @(negedge clk_i) begin
    word_vec_t exp;
    if (rst_ni && rsp_valid_o) begin
      rsp_count++;
      if (exp_q.size() == 0) begin
        errors++;
        $display("%s: response pulse without an outstanding read", cur_test);
      end else begin
        exp = exp_q.pop_front();
        for (int i = 0; i < NB_CHAN; i++) begin
          check_word($sformatf("%s ch%0d", cur_test, i), exp[i], rsp_rdata_o[i]);
        end
      end
    end
  end

  initial begin
    repeat (TIMEOUT_CYC) @(posedge clk_i);
    $display("watchdog: run did not finish within %0d cycles", TIMEOUT_CYC);
    $display("Test FAILED");
    $finish;
  end

  initial begin
    word_idx_t w;
    rst_ni      = 1'b0;
    clear_i     = 1'b0;
    cmd_valid_i = 1'b0;
    cmd_read_i  = 1'b0;
    cmd_addr_i  = '0;
    cmd_be_i    = '0;
    cmd_wdata_i = '0;
    repeat (8) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    if (cmd_ready_o !== 1'b1 || rsp_valid_o !== 1'b0) begin
      errors++;
      $display("cmd_ready_o or rsp_valid_o has the wrong level after reset");
    end

    // fill every word with writes alone, which never answer
    start_test("write_only_fill");
    for (int unsigned k = 0; k < FILL_CMDS; k++) begin
      send_cmd(1'b0, word_idx_t'(k * NB_CHAN), '1, rand_words(), 1'b0);
    end
    idle(6, 1'b0);
    check_count("write_only_fill pulses", 0, rsp_count - rsp_start);
    end_test();

    start_test("aligned_rw");
    send_cmd(1'b0, word_idx_t'(32), '1, rand_words(), 1'b0);
    send_cmd(1'b1, word_idx_t'(32), '0, '0, 1'b1);
    idle(1, 1'b0);
    wait_drain();
    end_test();

    // writes at base words 64, 69, 74, 79 give every order
    // reading one word higher moves each word to another channel
    start_test("rotation");
    for (int unsigned k = 0; k < NB_BANK; k++) begin
      send_cmd(1'b0, word_idx_t'(64 + 5 * k), '1, rand_words(), 1'b0);
      send_cmd(1'b1, word_idx_t'(65 + 5 * k), '0, '0, 1'b1);
    end
    idle(1, 1'b0);
    wait_drain();
    end_test();

    start_test("partial_be");
    send_cmd(1'b0, word_idx_t'(130), '1, rand_words(), 1'b0);
    send_cmd(1'b0, word_idx_t'(130), {4'b1100, 4'b1010, 4'b0110, 4'b0001}, rand_words(), 1'b0);
    send_cmd(1'b1, word_idx_t'(130), '0, '0, 1'b1);
    idle(1, 1'b0);
    wait_drain();
    end_test();

    // back to back, so three reads are in flight
    start_test("random_reads");
    for (int unsigned k = 0; k < RAND_READS; k++) begin
      w = word_idx_t'(take_bits(8));
      if (w > word_idx_t'(TOTAL_WORDS - NB_CHAN)) begin
        w = w - word_idx_t'(NB_CHAN);
      end
      send_cmd(1'b1, w, '0, '0, 1'b1);
    end
    idle(1, 1'b0);
    wait_drain();
    idle(3, 1'b0);
    check_count("random_reads pulses", RAND_READS, rsp_count - rsp_start);
    end_test();

    start_test("clear_in_flight");
    send_cmd(1'b1, word_idx_t'(200), '0, '0, 1'b0);
    idle(1, 1'b1);
    idle(6, 1'b0);
    check_count("clear_in_flight pulses after clear", 0, rsp_count - rsp_start);
    send_cmd(1'b1, word_idx_t'(201), '0, '0, 1'b1);
    idle(1, 1'b0);
    wait_drain();
    check_count("clear_in_flight pulses after recovery", 1, rsp_count - rsp_start);
    end_test();

    idle(2, 1'b0);
    $display("tests run: %0d, failed: %0d, checks: %0d, errors: %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: project.f
hw/tcdm_pkg.sv
hw/tcdm_intf.sv
hw/tcdm_chan_decode.sv
hw/tcdm_reorder.sv
hw/tcdm_bank_mem.sv
hw/tcdm_resp_collect.sv
hw/tcdm_subsys_top.sv
tests/tcdm_subsys_assertions.sv
tests/tcdm_subsys_tb.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, then judge the run by its log
rm -f sim.log
verilator --binary --timing --assert -f project.f --top-module tcdm_subsys_tb -o tcdm_sim \
  && ./obj_dir/tcdm_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Test OK" sim.log && echo "simulation passed" && exit 0 \
  || { echo "simulation failed"; exit 1; }
